// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and address bus share one width
`define CPU_DATA_W 8

// General registers R1 to R4
`define CPU_REG_CNT 4

// First fetch address
`define CPU_RESET_PC 8'h00

`endif

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    // Instruction word, low byte stored at the lower address
    //   15..12  opcode
    //   ALU ops      11..8 destination, 7..4 source 1, 3..0 source 2 (low two bits used)
    //   LD ST BRA BNE  bit 10 direct mode, 9..8 register, 7..0 address or immediate

    typedef logic [`CPU_DATA_W-1:0] byteT;
    typedef logic [$clog2(`CPU_REG_CNT)-1:0] regIdxT; // 0 selects R1

    typedef enum logic [1:0] {
        FETCH_LO,
        FETCH_HI,
        EXEC,
        EXEC2
    } stateT;

    typedef enum logic [3:0] {
        AND  = 4'd0,
        OR   = 4'd1,
        NOT  = 4'd2,
        ADD  = 4'd3,
        SUB  = 4'd4,
        LSR  = 4'd5,
        LSL  = 4'd6,
        INC  = 4'd7,  // No-op
        DEC  = 4'd8,  // No-op
        BRA  = 4'd9,
        BNE  = 4'd10,
        MOV  = 4'd11,
        LD   = 4'd12,
        ST   = 4'd13,
        PULL = 4'd14, // No-op
        PUSH = 4'd15  // No-op
    } opcodeT;

    typedef enum logic [2:0] {
        AND_OP,
        OR_OP,
        NOT_OP,
        ADD_OP,
        SUB_OP,
        LSR_OP,
        LSL_OP,
        PASS_OP
    } aluOpT;

    typedef enum logic [1:0] {
        SRC_ALU,
        SRC_IMM,
        SRC_MEM
    } rfSrcT;

endpackage

`default_nettype wire

// File: design/controlFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module controlFsm import cpu_pkg::*; (
    input  logic   clock,
    input  logic   rstN,
    input  byteT   memRdData,
    input  logic   zero,
    output aluOpT  aluOp,
    output logic   flagWe,
    output regIdxT rdSelA,
    output regIdxT rdSelB,
    output regIdxT wrSel,
    output logic   rfWe,
    output rfSrcT  rfSrc,
    output byteT   immByte,
    output logic   pcInc,
    output logic   pcLoad,
    output logic   pcFromMem,
    output logic   arLoad,
    output logic   addrFromAr,
    output logic   memWe
);

    stateT state;
    stateT nextState;
    logic [2*`CPU_DATA_W-1:0] ir;

    opcodeT opcode;
    logic   direct;
    regIdxT regSel;
    regIdxT src1;
    regIdxT src2;
    logic   jump;

    assign opcode = opcodeT'(ir[15:12]);
    assign direct = ir[10];
    assign regSel = ir[9:8]; // ALU destination uses the same bits
    assign src1 = ir[5:4];
    assign src2 = ir[1:0];

    // BRA always taken, BNE only while Z is clear
    assign jump = (opcode == BRA) || ((opcode == BNE) && !zero);

    assign immByte = ir[7:0];
    assign wrSel = regSel;
    assign rdSelA = src1;
    assign rdSelB = (opcode == ST) ? regSel : src2; // ST data leaves on port B

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= FETCH_LO;
            ir <= '0;
        end else begin
            state <= nextState;
            if (state == FETCH_LO) begin
                ir[7:0] <= memRdData;
            end
            if (state == FETCH_HI) begin
                ir[15:8] <= memRdData;
            end
        end
    end

    always_comb begin
        case (opcode)
            AND:     aluOp = AND_OP;
            OR:      aluOp = OR_OP;
            NOT:     aluOp = NOT_OP;
            ADD:     aluOp = ADD_OP;
            SUB:     aluOp = SUB_OP;
            LSR:     aluOp = LSR_OP;
            LSL:     aluOp = LSL_OP;
            default: aluOp = PASS_OP; // MOV
        endcase
    end

    always_comb begin
        nextState = FETCH_LO;
        flagWe = 1'b0;
        rfWe = 1'b0;
        rfSrc = SRC_ALU;
        pcInc = 1'b0;
        pcLoad = 1'b0;
        pcFromMem = 1'b0;
        arLoad = 1'b0;
        addrFromAr = 1'b0;
        memWe = 1'b0;

        case (state)
            FETCH_LO: begin
                pcInc = 1'b1;
                nextState = FETCH_HI;
            end
            FETCH_HI: begin
                pcInc = 1'b1;
                nextState = EXEC;
            end
            EXEC: begin
                case (opcode)
                    AND, OR, NOT, ADD, SUB, LSR, LSL, MOV: begin
                        rfWe = 1'b1;
                        flagWe = 1'b1;
                    end
                    LD: begin
                        if (direct) begin
                            arLoad = 1'b1;
                            nextState = EXEC2;
                        end else begin
                            rfWe = 1'b1;
                            rfSrc = SRC_IMM;
                        end
                    end
                    ST: begin
                        arLoad = 1'b1; // Direct regardless of mode bit
                        nextState = EXEC2;
                    end
                    BRA, BNE: begin
                        if (jump && direct) begin
                            arLoad = 1'b1;
                            nextState = EXEC2;
                        end else if (jump) begin
                            pcLoad = 1'b1;
                        end
                    end
                    default: ; // INC DEC PULL PUSH idle here
                endcase
            end
            EXEC2: begin
                addrFromAr = 1'b1;
                case (opcode)
                    LD: begin
                        rfWe = 1'b1;
                        rfSrc = SRC_MEM;
                    end
                    ST: memWe = 1'b1;
                    BRA, BNE: begin
                        pcLoad = 1'b1; // Target read from memory
                        pcFromMem = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module regFile import cpu_pkg::*; (
    input  logic   clock,
    input  logic   rstN,
    input  regIdxT rdSelA,
    input  regIdxT rdSelB,
    input  regIdxT wrSel,
    input  logic   we,
    input  rfSrcT  src,
    input  byteT   aluResult,
    input  byteT   immByte,
    input  byteT   memRdData,
    output byteT   outA,
    output byteT   outB
);

    byteT regs [`CPU_REG_CNT];
    byteT wrData;

    always_comb begin
        case (src)
            SRC_IMM: wrData = immByte;
            SRC_MEM: wrData = memRdData;
            default: wrData = aluResult;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < `CPU_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wrSel] <= wrData;
        end
    end

    assign outA = regs[rdSelA];
    assign outB = regs[rdSelB]; // Also the store data

endmodule

`default_nettype wire

// File: design/addrRegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module addrRegFile import cpu_pkg::*; (
    input  logic clock,
    input  logic rstN,
    input  logic pcInc,
    input  logic pcLoad,
    input  logic pcFromMem,
    input  logic arLoad,
    input  logic addrFromAr,
    input  byteT immByte,
    input  byteT memRdData,
    output byteT memAddr
);

    byteT pc;
    byteT ar;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pc <= `CPU_RESET_PC;
            ar <= '0;
        end else begin
            if (pcLoad) begin
                pc <= pcFromMem ? memRdData : immByte;
            end else if (pcInc) begin
                pc <= pc + 1'b1; // Wraps at 0xFF
            end
            if (arLoad) begin
                ar <= immByte;
            end
        end
    end

    // Data phase of LD, ST and direct branches
    assign memAddr = addrFromAr ? ar : pc;

endmodule

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic  clock,
    input  logic  rstN,
    input  aluOpT op,
    input  byteT  a,
    input  byteT  b,
    input  logic  flagWe,
    output byteT  result,
    output logic  zero
);

    always_comb begin
        case (op)
            AND_OP:  result = a & b;
            OR_OP:   result = a | b;
            NOT_OP:  result = ~a;
            ADD_OP:  result = a + b; // Carry dropped
            SUB_OP:  result = a - b;
            LSR_OP:  result = a >> 1;
            LSL_OP:  result = a << 1;
            default: result = a;     // PASS_OP
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            zero <= 1'b0;
        end else if (flagWe) begin
            zero <= (result == '0);
        end
    end

endmodule

`default_nettype wire

// File: design/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpu_pkg::*; (
    input  logic clock,
    input  logic rstN,
    input  byteT memRdData,
    output byteT memAddr,
    output logic memWe,
    output byteT memWrData
);

    aluOpT  aluOp;
    logic   flagWe;
    logic   zero;
    regIdxT rdSelA;
    regIdxT rdSelB;
    regIdxT wrSel;
    logic   rfWe;
    rfSrcT  rfSrc;
    byteT   immByte;
    logic   pcInc;
    logic   pcLoad;
    logic   pcFromMem;
    logic   arLoad;
    logic   addrFromAr;
    byteT   aluResult;
    byteT   regA;

    controlFsm u_ctrl (
        .clock      (clock),
        .rstN       (rstN),
        .memRdData  (memRdData),
        .zero       (zero),
        .aluOp      (aluOp),
        .flagWe     (flagWe),
        .rdSelA     (rdSelA),
        .rdSelB     (rdSelB),
        .wrSel      (wrSel),
        .rfWe       (rfWe),
        .rfSrc      (rfSrc),
        .immByte    (immByte),
        .pcInc      (pcInc),
        .pcLoad     (pcLoad),
        .pcFromMem  (pcFromMem),
        .arLoad     (arLoad),
        .addrFromAr (addrFromAr),
        .memWe      (memWe)
    );

    regFile u_rf (
        .clock     (clock),
        .rstN      (rstN),
        .rdSelA    (rdSelA),
        .rdSelB    (rdSelB),
        .wrSel     (wrSel),
        .we        (rfWe),
        .src       (rfSrc),
        .aluResult (aluResult),
        .immByte   (immByte),
        .memRdData (memRdData),
        .outA      (regA),
        .outB      (memWrData) // Port B feeds both ALU and store
    );

    addrRegFile u_arf (
        .clock      (clock),
        .rstN       (rstN),
        .pcInc      (pcInc),
        .pcLoad     (pcLoad),
        .pcFromMem  (pcFromMem),
        .arLoad     (arLoad),
        .addrFromAr (addrFromAr),
        .immByte    (immByte),
        .memRdData  (memRdData),
        .memAddr    (memAddr)
    );

    alu u_alu (
        .clock  (clock),
        .rstN   (rstN),
        .op     (aluOp),
        .a      (regA),
        .b      (memWrData),
        .flagWe (flagWe),
        .result (aluResult),
        .zero   (zero)
    );

endmodule

`default_nettype wire

// File: test/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpuProps import cpu_pkg::*; (
    input logic   clock,
    input logic   rstN,
    input stateT  state,
    input opcodeT opcode,
    input logic   memWe
);

    // Stores write only in their data phase
    weOnlyInStore: assert property (@(posedge clock) disable iff (!rstN)
        memWe |-> (state == EXEC2) && (opcode == ST))
        else $error("memWe high outside the ST data phase");

    execTwoReturns: assert property (@(posedge clock) disable iff (!rstN)
        (state == EXEC2) |=> (state == FETCH_LO))
        else $error("EXEC2 was not followed by FETCH_LO");

    quietAfterReset: assert property (@(posedge clock)
        $rose(rstN) |-> !memWe)
        else $error("memWe high in the first cycle after reset");

endmodule

bind controlFsm cpuProps u_props (
    .clock  (clock),
    .rstN   (rstN),
    .state  (state),
    .opcode (opcode),
    .memWe  (memWe)
);

`default_nettype wire

// File: test/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpuTb import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_INSTR = 2000;

    logic clock;
    logic rstN;
    byteT memRdData;
    byteT memAddr;
    logic memWe;
    byteT memWrData;

    byteT mem [256];
    byteT image [256]; // Loaded into mem while reset is held
    byteT modelMem [256];
    byteT modelReg [`CPU_REG_CNT];
    byteT modelPc;
    logic modelZero;

    int addrErrors;
    int dataErrors;
    int weErrors;

    cpuTop u_dut (
        .clock     (clock),
        .rstN      (rstN),
        .memRdData (memRdData),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memWrData (memWrData)
    );

    assign memRdData = mem[memAddr]; // Asynchronous read

    always @(posedge clock) begin
        if (!rstN) begin
            mem <= image;
        end else if (memWe) begin
            mem[memAddr] <= memWrData;
        end
    end

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((NUM_INSTR * 4 + 100) * CLK_PERIOD);
        $display("Timeout: the CPU did not complete %0d instructions", NUM_INSTR);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [15:0] encAlu(opcodeT op, logic [3:0] dst, logic [3:0] s1,
                                           logic [3:0] s2);
        return {op, dst, s1, s2};
    endfunction

    function automatic logic [15:0] encMem(opcodeT op, logic direct, regIdxT rsel, byteT val);
        return {op, 1'b0, direct, rsel, val};
    endfunction

    function automatic byteT aluRule(opcodeT op, byteT a, byteT b);
        case (op)
            AND:     return a & b;
            OR:      return a | b;
            NOT:     return ~a;
            ADD:     return a + b;
            SUB:     return a - b;
            LSR:     return {1'b0, a[7:1]};
            LSL:     return {a[6:0], 1'b0};
            default: return a; // MOV copies source 1
        endcase
    endfunction

    function automatic opcodeT randomAluOp();
        int k;
        k = int'($urandom % 8);
        if (k == 7) begin
            return MOV;
        end
        return opcodeT'(k[3:0]);
    endfunction

    function automatic opcodeT randomDropped();
        case ($urandom % 4)
            0:       return INC;
            1:       return DEC;
            2:       return PULL;
            default: return PUSH;
        endcase
    endfunction

    function automatic logic [15:0] randomInstr(byteT addr);
        int kind;
        logic direct;
        byteT dataAddr;
        byteT span;
        byteT fwdTarget;
        byteT anyTarget;
        kind = int'($urandom % 20);
        direct = 1'($urandom);
        dataAddr = 8'h80 | 8'($urandom);
        span = (8'h7C - addr) >> 1;
        fwdTarget = (span == 0) ? 8'h00 : addr + 8'd2 + 8'(2 * ($urandom % span));
        anyTarget = 8'(($urandom % 63) * 2);
        if (kind < 8) begin
            return encAlu(randomAluOp(), 4'($urandom), 4'($urandom), 4'($urandom));
        end else if (kind < 11) begin
            return encMem(LD, direct, 2'($urandom), direct ? dataAddr : 8'($urandom));
        end else if (kind < 14) begin
            return encMem(ST, direct, 2'($urandom), dataAddr); // Mode bit has no effect
        end else if (kind < 16) begin
            // Immediate jumps go forward so the program keeps moving
            return encMem(BRA, direct, 2'($urandom), direct ? dataAddr : fwdTarget);
        end else if (kind < 18) begin
            return encMem(BNE, direct, 2'($urandom), direct ? dataAddr : anyTarget);
        end
        return encAlu(randomDropped(), 4'($urandom), 4'($urandom), 4'($urandom));
    endfunction

    task automatic placeWord(input byteT addr, input logic [15:0] word);
        image[addr] = word[7:0];
        image[addr + 8'd1] = word[15:8];
    endtask

    task automatic buildProgram();
        opcodeT op;
        for (int i = 0; i < 256; i++) begin
            image[i] = 8'(($urandom % 63) * 2); // Data bytes double as branch targets
        end
        placeWord(8'h00, encMem(LD, 1'b0, 2'd0, 8'h5A));
        placeWord(8'h02, encMem(LD, 1'b0, 2'd1, 8'h0F));
        placeWord(8'h04, encAlu(ADD, 4'd2, 4'd0, 4'd1));
        placeWord(8'h06, encMem(ST, 1'b1, 2'd2, 8'h80));
        placeWord(8'h08, encMem(LD, 1'b1, 2'd3, 8'h80));
        placeWord(8'h0A, encAlu(SUB, 4'd0, 4'd0, 4'd0)); // Sets Z
        placeWord(8'h0C, encMem(BNE, 1'b0, 2'd0, 8'h00)); // Falls through
        placeWord(8'h0E, encAlu(INC, 4'd0, 4'd0, 4'd0));
        placeWord(8'h10, encMem(BRA, 1'b1, 2'd0, 8'h81));
        placeWord(8'h12, encAlu(PUSH, 4'd0, 4'd0, 4'd0)); // Jumped over
        placeWord(8'h14, encMem(ST, 1'b1, 2'd3, 8'h82));
        image[8'h81] = 8'h14;
        // Every ALU op on R3 and R2 into R4, each result stored from 0x90 up
        for (int k = 0; k < 8; k++) begin
            op = (k == 7) ? MOV : opcodeT'(k[3:0]);
            placeWord(8'(8'h16 + 4 * k), encAlu(op, 4'd3, 4'd2, 4'd1));
            placeWord(8'(8'h18 + 4 * k), encMem(ST, 1'b1, 2'd3, 8'(8'h90 + k)));
        end
        placeWord(8'h36, encMem(BNE, 1'b0, 2'd0, 8'h3A)); // Z clear after MOV
        placeWord(8'h38, encAlu(PULL, 4'd0, 4'd0, 4'd0)); // Jumped over
        for (int a = 'h3A; a <= 'h7C; a += 2) begin
            placeWord(8'(a), randomInstr(8'(a)));
        end
        placeWord(8'h7E, encMem(BRA, 1'b0, 2'd0, 8'h00));
    endtask

    task automatic modelStep(output int cycles, output logic wr, output byteT wrAddr,
                             output byteT wrData);
        byteT lo;
        byteT hi;
        opcodeT op;
        regIdxT rsel;
        logic direct;
        logic taken;
        byteT res;
        lo = modelMem[modelPc];
        hi = modelMem[modelPc + 8'd1];
        modelPc = modelPc + 8'd2;
        op = opcodeT'(hi[7:4]);
        rsel = hi[1:0];
        direct = hi[2];
        cycles = 3;
        wr = 1'b0;
        wrAddr = '0;
        wrData = '0;
        case (op)
            AND, OR, NOT, ADD, SUB, LSR, LSL, MOV: begin
                res = aluRule(op, modelReg[lo[5:4]], modelReg[lo[1:0]]);
                modelReg[rsel] = res;
                modelZero = (res == 8'h00);
            end
            LD: begin
                modelReg[rsel] = direct ? modelMem[lo] : lo;
                cycles = direct ? 4 : 3;
            end
            ST: begin
                wr = 1'b1;
                wrAddr = lo;
                wrData = modelReg[rsel];
                modelMem[lo] = modelReg[rsel];
                cycles = 4;
            end
            BRA, BNE: begin
                taken = (op == BRA) || !modelZero;
                if (taken && direct) begin
                    modelPc = modelMem[lo];
                    cycles = 4;
                end else if (taken) begin
                    modelPc = lo;
                end
            end
            default: ; // INC DEC PULL PUSH
        endcase
    endtask

    task automatic checkAddr(input byteT expected);
        if (memAddr !== expected) begin
            addrErrors++;
            $display("FAIL memAddr: expected %h, got %h at %0t", expected, memAddr, $time);
        end
    endtask

    task automatic checkData(input byteT expected);
        if (memWrData !== expected) begin
            dataErrors++;
            $display("FAIL memWrData: expected %h, got %h at %0t", expected, memWrData, $time);
        end
    endtask

    task automatic checkWe(input logic expected);
        if (memWe !== expected) begin
            weErrors++;
            $display("FAIL memWe: expected %h, got %h at %0t", expected, memWe, $time);
        end
    endtask

    initial begin
        int cycles;
        logic wr;
        byteT wrAddr;
        byteT wrData;
        rstN = 1'b0;
        addrErrors = 0;
        dataErrors = 0;
        weErrors = 0;
        void'($urandom(1));
        buildProgram();
        modelMem = image;
        modelReg = '{default: '0};
        modelPc = `CPU_RESET_PC;
        modelZero = 1'b0;
        repeat (2) @(posedge clock);
        #1 rstN = 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            checkAddr(modelPc); // FETCH_LO
            checkWe(1'b0);
            modelStep(cycles, wr, wrAddr, wrData);
            for (int c = 2; c <= cycles; c++) begin
                @(posedge clock);
                #1;
                checkWe(wr && c == 4);
                if (wr && c == 4) begin
                    checkAddr(wrAddr);
                    checkData(wrData);
                end
            end
            @(posedge clock);
            #1;
        end
        $display("Errors: address %0d, data %0d, write enable %0d",
                 addrErrors, dataErrors, weErrors);
        if (addrErrors + dataErrors + weErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/cpu_pkg.sv
design/controlFsm.sv
design/regFile.sv
design/addrRegFile.sv
design/alu.sv
design/cpuTop.sv
test/cpu_props.sv
test/cpuTb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cpuTb
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
